// File: source/local_mem_pkg.sv
// ********************
// Shared widths, vector types and channel structs for the local memory port.
// The shim, the AXI memory and the top level refer to these by scoped names.
// ********************

`default_nettype none

package local_mem_pkg;

    // Avalon addresses whole lines while AXI addresses bytes
    localparam int LINE_ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 64;
    localparam int DATA_N_BYTES = DATA_WIDTH / 8;
    localparam int BYTE_IDX_WIDTH = $clog2(DATA_N_BYTES);
    localparam int AXI_ADDR_WIDTH = LINE_ADDR_WIDTH + BYTE_IDX_WIDTH;
    localparam int MEM_LINES = 1 << LINE_ADDR_WIDTH;

    // Avalon bursts run from 1 to 4 beats, and AXI lengths count from zero
    localparam int BURST_CNT_WIDTH = 3;
    localparam int AXI_LEN_WIDTH = BURST_CNT_WIDTH - 1;
    localparam int USER_WIDTH = 4;

    // Channel queue sizes inside the memory, as pointer widths
    localparam int AW_PTR_WIDTH = 1;
    localparam int W_PTR_WIDTH = 3;
    localparam int AR_PTR_WIDTH = 1;
    localparam int AW_QUEUE_DEPTH = 1 << AW_PTR_WIDTH;
    localparam int W_QUEUE_DEPTH = 1 << W_PTR_WIDTH;
    localparam int AR_QUEUE_DEPTH = 1 << AR_PTR_WIDTH;

    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DATA_N_BYTES-1:0] byte_en_t;
    typedef logic [BURST_CNT_WIDTH-1:0] burst_cnt_t;
    typedef logic [AXI_LEN_WIDTH-1:0] axi_len_t;
    typedef logic [USER_WIDTH-1:0] user_t;

    // Queue pointers carry one extra bit so that full and empty differ
    typedef logic [AW_PTR_WIDTH:0] aw_ptr_t;
    typedef logic [W_PTR_WIDTH:0] w_ptr_t;
    typedef logic [AR_PTR_WIDTH:0] ar_ptr_t;

    typedef struct packed {
        logic read;
        logic write;
        line_addr_t address;
        burst_cnt_t burstcount;
        data_t writedata;
        byte_en_t byteenable;
        user_t user;
    } avmm_req_t;

    typedef struct packed {
        axi_addr_t addr;
        axi_len_t len;
        logic [2:0] size;
        user_t user;
    } axi_aw_t;

    typedef struct packed {
        axi_addr_t addr;
        axi_len_t len;
        logic [2:0] size;
        user_t user;
    } axi_ar_t;

    typedef struct packed {
        data_t data;
        byte_en_t strb;
        logic last;
    } axi_w_t;

    typedef struct packed {
        user_t user;
    } axi_b_t;

    typedef struct packed {
        data_t data;
        logic last;
        user_t user;
    } axi_r_t;

    typedef enum logic {
        WR_IDLE,
        WR_BURST
    } wr_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_BURST
    } rd_state_t;

endpackage

`default_nettype wire

// File: source/burst_sop_tracker.sv
// ********************
// Follows the beats of Avalon write bursts.
// Flags the beat that opens a burst and the beat that closes it, so the
// shim can send one write address per burst and mark the last data beat.
// ********************

`timescale 1ns/1ps
`default_nettype none

module burst_sop_tracker
(
    input  logic clk,
    input  logic reset,
    input  logic flit_valid,
    input  local_mem_pkg::burst_cnt_t burstcount,
    output logic sop,
    output logic eop
);

    // Beats still owed by the burst in progress
    local_mem_pkg::burst_cnt_t beats_left;
    // High while the next accepted write beat opens a new burst
    logic at_start;

    assign sop = at_start;

    // The burst count is only valid on the first beat, later beats use the counter
    assign eop = at_start ? (burstcount == local_mem_pkg::burst_cnt_t'(1))
                          : (beats_left == local_mem_pkg::burst_cnt_t'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            at_start <= 1'b1;
            beats_left <= '0;
        end
        else if (flit_valid)
        begin
            // A closing beat hands the next beat a fresh start
            at_start <= eop;
            beats_left <= (at_start ? burstcount : beats_left)
                          - local_mem_pkg::burst_cnt_t'(1);
        end
    end

    // A zero length burst would leave the counter wrapped and the shim stuck
    burstcount_nonzero: assert property (@(posedge clk) disable iff (reset)
        flit_valid && sop |-> burstcount != '0);

endmodule

`default_nettype wire

// File: source/avalon_to_axi_shim.sv
// ********************
// Maps an Avalon-MM master onto the five AXI-MM channels.
// Avalon line addresses become AXI byte addresses, burst counts become
// zero based lengths, and responses flow straight back with their tags.
// The path is combinational apart from the write burst tracker.
// ********************

`timescale 1ns/1ps
`default_nettype none

module avalon_to_axi_shim
(
    input  logic clk,
    input  logic reset,

    // Avalon-MM side, facing the accelerator
    input  local_mem_pkg::avmm_req_t avmm_req,
    output logic waitrequest,
    output logic readdatavalid,
    output local_mem_pkg::data_t readdata,
    output local_mem_pkg::user_t readuser,
    output logic writeresponsevalid,
    output local_mem_pkg::user_t writeuser,

    // AXI-MM side, facing the memory
    output logic awvalid,
    input  logic awready,
    output local_mem_pkg::axi_aw_t aw,
    output logic wvalid,
    input  logic wready,
    output local_mem_pkg::axi_w_t w,
    output logic arvalid,
    input  logic arready,
    output local_mem_pkg::axi_ar_t ar,
    input  logic bvalid,
    output logic bready,
    input  local_mem_pkg::axi_b_t b,
    input  logic rvalid,
    output logic rready,
    input  local_mem_pkg::axi_r_t r
);

    logic wr_is_sop;
    logic wr_is_eop;
    local_mem_pkg::axi_addr_t byte_addr;
    local_mem_pkg::axi_len_t axi_len;

    // Count accepted write beats only, reads carry a whole burst in one command
    burst_sop_tracker wr_bursts
    (
        .clk(clk),
        .reset(reset),
        .flit_valid(avmm_req.write && !waitrequest),
        .burstcount(avmm_req.burstcount),
        .sop(wr_is_sop),
        .eop(wr_is_eop)
    );

    // Stall on any channel that could not take the beat
    // The memory keeps its readies independent of valid, so there is no loop here
    assign waitrequest = (avmm_req.write && wr_is_sop && !awready) || !wready || !arready;

    // Pad the line address with zero byte index bits
    assign byte_addr = {avmm_req.address, {local_mem_pkg::BYTE_IDX_WIDTH{1'b0}}};
    assign axi_len = local_mem_pkg::axi_len_t'(avmm_req.burstcount
                     - local_mem_pkg::burst_cnt_t'(1));

    // The write address goes out once, on the opening beat of a burst
    assign awvalid = avmm_req.write && !waitrequest && wr_is_sop;
    assign aw = '{
        addr: byte_addr,
        len: axi_len,
        size: 3'(local_mem_pkg::BYTE_IDX_WIDTH),
        user: avmm_req.user
    };

    // Every accepted write beat becomes one data beat
    assign wvalid = avmm_req.write && !waitrequest;
    assign w = '{
        data: avmm_req.writedata,
        strb: avmm_req.byteenable,
        last: wr_is_eop
    };

    assign arvalid = avmm_req.read && !waitrequest;
    assign ar = '{
        addr: byte_addr,
        len: axi_len,
        size: 3'(local_mem_pkg::BYTE_IDX_WIDTH),
        user: avmm_req.user
    };

    // Avalon responses cannot stall, so both response readies stay high
    assign bready = 1'b1;
    assign writeresponsevalid = bvalid;
    assign writeuser = b.user;

    assign rready = 1'b1;
    assign readdatavalid = rvalid;
    assign readdata = r.data;
    assign readuser = r.user;

    // The burst address travels with its first data beat
    // A single beat burst must close on that same beat, as the tracker decides
    aw_with_w: assert property (@(posedge clk) disable iff (reset)
        awvalid |-> wvalid && (w.last == (aw.len == '0)));

    // The master issues one command type per cycle
    no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(avmm_req.read && avmm_req.write));

endmodule

`default_nettype wire

// File: source/axi_local_mem.sv
// ********************
// AXI-MM slave over a local line array.
// The aw, w and ar channels land in small circular queues, and the write
// and read engines drain them one beat per cycle. Responses return in
// order per channel and carry the user tag of their request.
// ********************

`timescale 1ns/1ps
`default_nettype none

module axi_local_mem
(
    input  logic clk,
    input  logic reset,

    input  logic awvalid,
    output logic awready,
    input  local_mem_pkg::axi_aw_t aw,
    input  logic wvalid,
    output logic wready,
    input  local_mem_pkg::axi_w_t w,
    input  logic arvalid,
    output logic arready,
    input  local_mem_pkg::axi_ar_t ar,
    output logic bvalid,
    input  logic bready,
    output local_mem_pkg::axi_b_t b,
    output logic rvalid,
    input  logic rready,
    output local_mem_pkg::axi_r_t r
);

    // Queue storage and pointers, the pointer difference is the fill level
    local_mem_pkg::axi_aw_t aw_queue [local_mem_pkg::AW_QUEUE_DEPTH];
    local_mem_pkg::axi_w_t w_queue [local_mem_pkg::W_QUEUE_DEPTH];
    local_mem_pkg::axi_ar_t ar_queue [local_mem_pkg::AR_QUEUE_DEPTH];
    local_mem_pkg::aw_ptr_t aw_wr_ptr;
    local_mem_pkg::aw_ptr_t aw_rd_ptr;
    local_mem_pkg::aw_ptr_t aw_used;
    local_mem_pkg::w_ptr_t w_wr_ptr;
    local_mem_pkg::w_ptr_t w_rd_ptr;
    local_mem_pkg::w_ptr_t w_used;
    local_mem_pkg::ar_ptr_t ar_wr_ptr;
    local_mem_pkg::ar_ptr_t ar_rd_ptr;
    local_mem_pkg::ar_ptr_t ar_used;
    local_mem_pkg::axi_aw_t aw_head;
    local_mem_pkg::axi_w_t w_head;
    local_mem_pkg::axi_ar_t ar_head;
    logic aw_pop;
    logic w_pop;
    logic ar_pop;

    // The line array itself
    local_mem_pkg::data_t mem_lines [local_mem_pkg::MEM_LINES];

    // Write engine state
    local_mem_pkg::wr_state_t wr_state;
    local_mem_pkg::axi_len_t wr_beats_left;
    local_mem_pkg::line_addr_t wr_line;
    local_mem_pkg::user_t wr_user;
    logic wr_last_beat;
    logic b_free;

    // Read engine state
    local_mem_pkg::rd_state_t rd_state;
    local_mem_pkg::axi_len_t rd_beats_left;
    local_mem_pkg::line_addr_t rd_line;
    local_mem_pkg::line_addr_t rd_fetch_line;
    local_mem_pkg::user_t rd_user;
    local_mem_pkg::data_t r_data;
    logic rd_fetch;

    assign aw_used = aw_wr_ptr - aw_rd_ptr;
    assign w_used = w_wr_ptr - w_rd_ptr;
    assign ar_used = ar_wr_ptr - ar_rd_ptr;

    // Readies look only at the fill level, never at the incoming valid
    assign awready = aw_used != local_mem_pkg::aw_ptr_t'(local_mem_pkg::AW_QUEUE_DEPTH);
    assign wready = w_used != local_mem_pkg::w_ptr_t'(local_mem_pkg::W_QUEUE_DEPTH);
    assign arready = ar_used != local_mem_pkg::ar_ptr_t'(local_mem_pkg::AR_QUEUE_DEPTH);

    assign aw_head = aw_queue[aw_rd_ptr[local_mem_pkg::AW_PTR_WIDTH-1:0]];
    assign w_head = w_queue[w_rd_ptr[local_mem_pkg::W_PTR_WIDTH-1:0]];
    assign ar_head = ar_queue[ar_rd_ptr[local_mem_pkg::AR_PTR_WIDTH-1:0]];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            aw_wr_ptr <= '0;
            aw_rd_ptr <= '0;
            w_wr_ptr <= '0;
            w_rd_ptr <= '0;
            ar_wr_ptr <= '0;
            ar_rd_ptr <= '0;
        end
        else
        begin
            if (awvalid && awready)
                aw_wr_ptr <= aw_wr_ptr + local_mem_pkg::aw_ptr_t'(1);
            if (aw_pop)
                aw_rd_ptr <= aw_rd_ptr + local_mem_pkg::aw_ptr_t'(1);
            if (wvalid && wready)
                w_wr_ptr <= w_wr_ptr + local_mem_pkg::w_ptr_t'(1);
            if (w_pop)
                w_rd_ptr <= w_rd_ptr + local_mem_pkg::w_ptr_t'(1);
            if (arvalid && arready)
                ar_wr_ptr <= ar_wr_ptr + local_mem_pkg::ar_ptr_t'(1);
            if (ar_pop)
                ar_rd_ptr <= ar_rd_ptr + local_mem_pkg::ar_ptr_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (awvalid && awready)
            aw_queue[aw_wr_ptr[local_mem_pkg::AW_PTR_WIDTH-1:0]] <= aw;
        if (wvalid && wready)
            w_queue[w_wr_ptr[local_mem_pkg::W_PTR_WIDTH-1:0]] <= w;
        if (arvalid && arready)
            ar_queue[ar_wr_ptr[local_mem_pkg::AR_PTR_WIDTH-1:0]] <= ar;
    end

    // The write engine takes a new address only when idle
    assign aw_pop = (wr_state == local_mem_pkg::WR_IDLE) && (aw_used != '0);
    assign wr_last_beat = (wr_beats_left == '0);

    // The closing beat waits until the previous response has left
    assign b_free = !bvalid || bready;
    assign w_pop = (wr_state == local_mem_pkg::WR_BURST) && (w_used != '0)
                   && (!wr_last_beat || b_free);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_state <= local_mem_pkg::WR_IDLE;
            wr_beats_left <= '0;
            bvalid <= 1'b0;
        end
        else
        begin
            if (bvalid && bready)
                bvalid <= 1'b0;
            if (aw_pop)
            begin
                wr_state <= local_mem_pkg::WR_BURST;
                wr_beats_left <= aw_head.len;
            end
            else if (w_pop)
            begin
                wr_beats_left <= wr_beats_left - local_mem_pkg::axi_len_t'(1);
                // Response rises in the cycle after the last line is written
                if (wr_last_beat)
                begin
                    wr_state <= local_mem_pkg::WR_IDLE;
                    bvalid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (aw_pop)
        begin
            wr_line <= aw_head.addr[local_mem_pkg::AXI_ADDR_WIDTH-1:local_mem_pkg::BYTE_IDX_WIDTH];
            wr_user <= aw_head.user;
        end
        else if (w_pop)
            wr_line <= wr_line + local_mem_pkg::line_addr_t'(1);
        // Latch the tag with the response so a following burst cannot disturb it
        if (w_pop && wr_last_beat)
            b <= '{user: wr_user};
    end

    // The read engine pops a command and streams its beats back to back
    assign ar_pop = (rd_state == local_mem_pkg::RD_IDLE) && (ar_used != '0);
    assign rvalid = (rd_state == local_mem_pkg::RD_BURST);

    // Fetch the first line on the pop and the next line on every accepted beat
    assign rd_fetch = ar_pop || (rvalid && rready && (rd_beats_left != '0));
    assign rd_fetch_line = ar_pop
        ? ar_head.addr[local_mem_pkg::AXI_ADDR_WIDTH-1:local_mem_pkg::BYTE_IDX_WIDTH]
        : rd_line + local_mem_pkg::line_addr_t'(1);

    assign r = '{data: r_data, last: (rd_beats_left == '0), user: rd_user};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_state <= local_mem_pkg::RD_IDLE;
            rd_beats_left <= '0;
        end
        else if (ar_pop)
        begin
            rd_state <= local_mem_pkg::RD_BURST;
            rd_beats_left <= ar_head.len;
        end
        else if (rvalid && rready)
        begin
            if (rd_beats_left == '0)
                rd_state <= local_mem_pkg::RD_IDLE;
            else
                rd_beats_left <= rd_beats_left - local_mem_pkg::axi_len_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (ar_pop)
            rd_user <= ar_head.user;
    end

    // Line array with byte merged writes and a registered read port
    always_ff @(posedge clk)
    begin
        if (w_pop)
        begin
            for (int i = 0; i < local_mem_pkg::DATA_N_BYTES; i++)
            begin
                if (w_head.strb[i])
                    mem_lines[wr_line][8*i +: 8] <= w_head.data[8*i +: 8];
            end
        end
        if (rd_fetch)
        begin
            r_data <= mem_lines[rd_fetch_line];
            rd_line <= rd_fetch_line;
        end
    end

    // The shim's last flag and the queued aw length must agree beat for beat
    w_last_matches_len: assert property (@(posedge clk) disable iff (reset)
        w_pop |-> (w_head.last == wr_last_beat));

endmodule

`default_nettype wire

// File: source/local_mem_top.sv
// ********************
// Local memory port as seen by an accelerator.
// An Avalon-MM master enters here, the shim turns it into AXI-MM, and the
// AXI memory answers. Only wires sit between the two blocks.
// ********************

`timescale 1ns/1ps
`default_nettype none

module local_mem_top
(
    input  logic clk,
    input  logic reset,
    input  local_mem_pkg::avmm_req_t avmm_req,
    output logic waitrequest,
    output logic readdatavalid,
    output local_mem_pkg::data_t readdata,
    output local_mem_pkg::user_t readuser,
    output logic writeresponsevalid,
    output local_mem_pkg::user_t writeuser
);

    // AXI channels between the shim and the memory
    logic awvalid;
    logic awready;
    local_mem_pkg::axi_aw_t aw;
    logic wvalid;
    logic wready;
    local_mem_pkg::axi_w_t w;
    logic arvalid;
    logic arready;
    local_mem_pkg::axi_ar_t ar;
    logic bvalid;
    logic bready;
    local_mem_pkg::axi_b_t b;
    logic rvalid;
    logic rready;
    local_mem_pkg::axi_r_t r;

    avalon_to_axi_shim i_shim
    (
        .clk(clk),
        .reset(reset),
        .avmm_req(avmm_req),
        .waitrequest(waitrequest),
        .readdatavalid(readdatavalid),
        .readdata(readdata),
        .readuser(readuser),
        .writeresponsevalid(writeresponsevalid),
        .writeuser(writeuser),
        .awvalid(awvalid),
        .awready(awready),
        .aw(aw),
        .wvalid(wvalid),
        .wready(wready),
        .w(w),
        .arvalid(arvalid),
        .arready(arready),
        .ar(ar),
        .bvalid(bvalid),
        .bready(bready),
        .b(b),
        .rvalid(rvalid),
        .rready(rready),
        .r(r)
    );

    axi_local_mem i_mem
    (
        .clk(clk),
        .reset(reset),
        .awvalid(awvalid),
        .awready(awready),
        .aw(aw),
        .wvalid(wvalid),
        .wready(wready),
        .w(w),
        .arvalid(arvalid),
        .arready(arready),
        .ar(ar),
        .bvalid(bvalid),
        .bready(bready),
        .b(b),
        .rvalid(rvalid),
        .rready(rready),
        .r(r)
    );

endmodule

`default_nettype wire

// File: dv/local_mem_tb_tasks.svh
// ********************
// Reference model, checks and Avalon driving tasks for the local memory
// testbench. Included inside the testbench module after its signals and
// scoreboard queues have been declared.
// ********************

`ifndef LOCAL_MEM_TB_TASKS_SVH
`define LOCAL_MEM_TB_TASKS_SVH

// Expected contents of every line, updated only when a write response arrives
local_mem_pkg::data_t shadow [local_mem_pkg::MEM_LINES];

// Each enabled byte takes the new value, the others keep the old line
function automatic local_mem_pkg::data_t ref_merge(input local_mem_pkg::data_t old_line,
    input local_mem_pkg::data_t new_line, input local_mem_pkg::byte_en_t byteenable);
    local_mem_pkg::data_t merged;
    merged = old_line;
    for (int i = 0; i < local_mem_pkg::DATA_N_BYTES; i++)
    begin
        if (byteenable[i])
            merged[8*i +: 8] = new_line[8*i +: 8];
    end
    return merged;
endfunction

task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failure");
endtask

task automatic check_value(input string name, input logic [63:0] actual,
    input logic [63:0] expected);
    if (actual !== expected)
    begin
        error_count++;
        $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    end
endtask

// Called on a rising edge, returns on the rising edge that accepted the beat
task automatic send_beat(input local_mem_pkg::avmm_req_t req);
    int wait_cycles;
    avmm_req <= req;
    wait_cycles = 0;
    @(negedge clk);
    // waitrequest is sampled mid cycle where it has settled
    while (waitrequest)
    begin
        wait_cycles++;
        if (wait_cycles > TIMEOUT_CYCLES)
            report_failure("Timeout: waitrequest stayed high and the beat was never accepted");
        @(negedge clk);
    end
    @(posedge clk);
endtask

// Beats come from stage_data and stage_be, and the scoreboard learns of the burst first
task automatic write_burst(input local_mem_pkg::line_addr_t line,
    input local_mem_pkg::burst_cnt_t count, input local_mem_pkg::user_t user);
    local_mem_pkg::avmm_req_t req;
    local_mem_pkg::line_addr_t beat_line;
    wr_line_q.push_back(line);
    wr_cnt_q.push_back(count);
    wr_user_q.push_back(user);
    for (int k = 0; k < int'(count); k++)
    begin
        beat_line = line + local_mem_pkg::line_addr_t'(k);
        pending_wr[beat_line]++;
        wr_data_q.push_back(stage_data[k]);
        wr_be_q.push_back(stage_be[k]);
    end
    for (int k = 0; k < int'(count); k++)
    begin
        req = '0;
        req.write = 1'b1;
        req.address = line;
        req.burstcount = count;
        req.writedata = stage_data[k];
        req.byteenable = stage_be[k];
        req.user = user;
        send_beat(req);
    end
endtask

// One command covers the whole burst, and the expected beats come from the shadow now
task automatic read_burst(input local_mem_pkg::line_addr_t line,
    input local_mem_pkg::burst_cnt_t count, input local_mem_pkg::user_t user);
    local_mem_pkg::avmm_req_t req;
    local_mem_pkg::line_addr_t beat_line;
    for (int k = 0; k < int'(count); k++)
    begin
        beat_line = line + local_mem_pkg::line_addr_t'(k);
        pending_rd[beat_line]++;
        exp_rdata.push_back(shadow[beat_line]);
        exp_ruser.push_back(user);
        exp_rline.push_back(beat_line);
    end
    req = '0;
    req.read = 1'b1;
    req.address = line;
    req.burstcount = count;
    req.user = user;
    send_beat(req);
endtask

`endif

// File: dv/local_mem_tb.sv
// ********************
// Testbench for the local memory port.
// Drives Avalon-MM bursts into the top level and checks every read beat
// and write response against a shadow model of the line array.
// Directed cases come first, then back to back random traffic.
// ********************

`timescale 1ns/1ps
`default_nettype none

module local_mem_tb;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_COMMANDS = 200;
    // Lines 0 to 63 are filled first and then used by the random traffic
    localparam int RANDOM_LINES = 64;
    // Cycles the port must stay silent once every response has arrived
    localparam int QUIET_CYCLES = 32;

    logic clk = 1'b0;
    logic reset;
    local_mem_pkg::avmm_req_t avmm_req;
    logic waitrequest;
    logic readdatavalid;
    local_mem_pkg::data_t readdata;
    local_mem_pkg::user_t readuser;
    logic writeresponsevalid;
    local_mem_pkg::user_t writeuser;

    int error_count = 0;
    int seed;

    // Beats of the next write burst
    local_mem_pkg::data_t stage_data [4];
    local_mem_pkg::byte_en_t stage_be [4];

    // Outstanding writes, one entry per burst and one data entry per beat
    local_mem_pkg::line_addr_t wr_line_q [$];
    local_mem_pkg::burst_cnt_t wr_cnt_q [$];
    local_mem_pkg::user_t wr_user_q [$];
    local_mem_pkg::data_t wr_data_q [$];
    local_mem_pkg::byte_en_t wr_be_q [$];

    // Outstanding read beats in the order they must return
    local_mem_pkg::data_t exp_rdata [$];
    local_mem_pkg::user_t exp_ruser [$];
    local_mem_pkg::line_addr_t exp_rline [$];

    // Beats still in flight per line, so reads and writes never race on a line
    int pending_wr [local_mem_pkg::MEM_LINES];
    int pending_rd [local_mem_pkg::MEM_LINES];

    `include "local_mem_tb_tasks.svh"

    always #4 clk = ~clk;

    local_mem_top i_dut
    (
        .clk(clk),
        .reset(reset),
        .avmm_req(avmm_req),
        .waitrequest(waitrequest),
        .readdatavalid(readdatavalid),
        .readdata(readdata),
        .readuser(readuser),
        .writeresponsevalid(writeresponsevalid),
        .writeuser(writeuser)
    );

    // Read beats are compared in issue order, the valid lasts one cycle per beat
    always @(negedge clk)
    begin : read_monitor
        local_mem_pkg::line_addr_t beat_line;
        if (!reset && readdatavalid)
        begin
            if (exp_rdata.size() == 0)
                report_failure("Read data arrived while no read was outstanding");
            else
            begin
                check_value("readdata", readdata, exp_rdata.pop_front());
                check_value("readuser", 64'(readuser), 64'(exp_ruser.pop_front()));
                beat_line = exp_rline.pop_front();
                pending_rd[beat_line]--;
            end
        end
    end

    // A write response means its lines are in memory, so the shadow takes them now
    always @(negedge clk)
    begin : write_monitor
        local_mem_pkg::line_addr_t line;
        local_mem_pkg::line_addr_t beat_line;
        local_mem_pkg::burst_cnt_t count;
        if (!reset && writeresponsevalid)
        begin
            if (wr_user_q.size() == 0)
                report_failure("Write response arrived while no write was outstanding");
            else
            begin
                check_value("writeuser", 64'(writeuser), 64'(wr_user_q.pop_front()));
                line = wr_line_q.pop_front();
                count = wr_cnt_q.pop_front();
                for (int k = 0; k < int'(count); k++)
                begin
                    beat_line = line + local_mem_pkg::line_addr_t'(k);
                    shadow[beat_line] = ref_merge(shadow[beat_line], wr_data_q.pop_front(),
                                                  wr_be_q.pop_front());
                    pending_wr[beat_line]--;
                end
            end
        end
    end

    // Reads must not see lines with writes in flight, writes must not pass pending reads
    function automatic logic range_clear(input local_mem_pkg::line_addr_t line,
        input local_mem_pkg::burst_cnt_t count, input logic is_write);
        logic clear;
        local_mem_pkg::line_addr_t beat_line;
        clear = 1'b1;
        for (int k = 0; k < int'(count); k++)
        begin
            beat_line = line + local_mem_pkg::line_addr_t'(k);
            if (is_write && pending_rd[beat_line] != 0)
                clear = 1'b0;
            if (!is_write && pending_wr[beat_line] != 0)
                clear = 1'b0;
        end
        return clear;
    endfunction

    // Idles the bus and returns on a rising edge once every response is in
    task automatic drain_responses();
        int wait_cycles;
        avmm_req <= '0;
        wait_cycles = 0;
        while (exp_rdata.size() != 0 || wr_user_q.size() != 0)
        begin
            wait_cycles++;
            if (wait_cycles > TIMEOUT_CYCLES)
                report_failure("Timeout: outstanding read or write responses never arrived");
            @(posedge clk);
        end
    endtask

    initial
    begin : stimulus
        int rnd;
        int d_hi;
        int d_lo;
        int idle_cycles;
        logic cmd_ok;
        logic is_write;
        local_mem_pkg::line_addr_t line;
        local_mem_pkg::burst_cnt_t count;
        local_mem_pkg::user_t user;

        avmm_req = '0;
        reset = 1'b1;
        seed = 16120;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Empty queues mean no stall and no responses
        @(negedge clk);
        check_value("waitrequest", 64'(waitrequest), 64'h0);
        check_value("readdatavalid", 64'(readdatavalid), 64'h0);
        check_value("writeresponsevalid", 64'(writeresponsevalid), 64'h0);
        @(posedge clk);

        // Single beat write, then a read of the same line
        stage_data[0] = 64'h0123_4567_89ab_cdef;
        stage_be[0] = 8'hff;
        write_burst(10'd900, 3'd1, 4'h3);
        drain_responses();
        read_burst(10'd900, 3'd1, 4'h4);
        drain_responses();

        // Four beat bursts fill the random region with an address based pattern
        for (int b = 0; b < RANDOM_LINES / 4; b++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                line = local_mem_pkg::line_addr_t'(4 * b + k);
                stage_data[k] = {16'hbeef, 6'd0, line, 16'h5a5a, 6'd0, ~line};
                stage_be[k] = 8'hff;
            end
            write_burst(local_mem_pkg::line_addr_t'(4 * b), 3'd4,
                        local_mem_pkg::user_t'(b));
        end
        drain_responses();
        for (int b = 0; b < RANDOM_LINES / 4; b++)
            read_burst(local_mem_pkg::line_addr_t'(4 * b), 3'd4, local_mem_pkg::user_t'(15 - b));
        drain_responses();

        // Two and three beat bursts over consecutive lines
        for (int k = 0; k < 4; k++)
        begin
            stage_data[k] = {32'h2b00_0000 + 32'(k), 32'hc0ff_ee00 + 32'(k)};
            stage_be[k] = 8'hff;
        end
        write_burst(10'd100, 3'd2, 4'h5);
        write_burst(10'd102, 3'd3, 4'h6);
        drain_responses();
        read_burst(10'd100, 3'd2, 4'h7);
        read_burst(10'd102, 3'd3, 4'h8);
        drain_responses();

        // Partial byte enables over lines that already hold known data
        for (int k = 0; k < 4; k++)
        begin
            stage_data[k] = {32'h1111_1111 * 32'(k + 1), 32'h0f0f_0f0f};
            stage_be[k] = 8'hff;
        end
        write_burst(10'd200, 3'd4, 4'h9);
        drain_responses();
        stage_be[0] = 8'h0f;
        stage_be[1] = 8'hf0;
        stage_be[2] = 8'h81;
        stage_be[3] = 8'h3c;
        for (int k = 0; k < 4; k++)
            stage_data[k] = {32'hfeed_0000 + 32'(k), 32'hface_0000 + 32'(k)};
        write_burst(10'd200, 3'd4, 4'ha);
        drain_responses();
        read_burst(10'd200, 3'd4, 4'hb);
        drain_responses();

        // Random traffic back to back, so the queues fill and waitrequest stalls
        for (int n = 0; n < RANDOM_COMMANDS; n++)
        begin
            cmd_ok = 1'b0;
            idle_cycles = 0;
            while (!cmd_ok)
            begin
                rnd = $random(seed);
                is_write = rnd[0];
                count = local_mem_pkg::burst_cnt_t'(rnd[2:1]) + 3'd1;
                user = local_mem_pkg::user_t'(rnd[6:3]);
                line = local_mem_pkg::line_addr_t'(rnd[12:7]);
                if (int'(line) > RANDOM_LINES - int'(count))
                    line = local_mem_pkg::line_addr_t'(RANDOM_LINES - int'(count));
                cmd_ok = range_clear(line, count, is_write);
                if (!cmd_ok)
                begin
                    // Let the conflicting beats retire before drawing again
                    idle_cycles++;
                    if (idle_cycles > TIMEOUT_CYCLES)
                        report_failure("Timeout: no random command could avoid busy lines");
                    avmm_req <= '0;
                    @(posedge clk);
                end
            end
            if (is_write)
            begin
                for (int k = 0; k < int'(count); k++)
                begin
                    d_hi = $random(seed);
                    d_lo = $random(seed);
                    rnd = $random(seed);
                    stage_data[k] = {d_hi, d_lo};
                    stage_be[k] = local_mem_pkg::byte_en_t'(rnd[7:0]);
                end
                write_burst(line, count, user);
            end
            else
                read_burst(line, count, user);
        end
        drain_responses();

        // Every burst has been answered once, so nothing more may come back
        repeat (QUIET_CYCLES)
        begin
            @(negedge clk);
            check_value("writeresponsevalid", 64'(writeresponsevalid), 64'h0);
            check_value("readdatavalid", 64'(readdatavalid), 64'h0);
        end

        if (error_count == 0)
        begin
            $display("All tests passed!");
            $finish;
        end
        else
        begin
            $display("Test failures found");
            $fatal(1, "simulation ended with failed checks");
        end
    end

endmodule

`default_nettype wire

// File: local_mem_avalon.f
+incdir+dv
source/local_mem_pkg.sv
source/burst_sop_tracker.sv
source/avalon_to_axi_shim.sv
source/axi_local_mem.sv
source/local_mem_top.sv
dv/local_mem_tb.sv

// File: Makefile
# Verilator flow for the local memory port testbench

TOP = local_mem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f local_mem_avalon.f --top-module $(TOP)

obj_dir/V$(TOP): local_mem_avalon.f source/*.sv dv/*.sv dv/*.svh
	verilator --binary --timing --assert -j 0 -f local_mem_avalon.f \
		--top-module $(TOP) -Mdir obj_dir

# The testbench ends every failing run with $fatal, so the exit status carries the result
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
